// ==== hw/roi_defs.svh ====
/* ROI detector constants
   widths, black/white level and end-of-row gap */

`ifndef ROI_DEFS_SVH
`define ROI_DEFS_SVH

// ==============================
// datapath widths
// ==============================
`define PIX_W   12   // ccd sample
`define RUN_W   10   // white run length
`define THR_W   11   // adaptive row threshold
`define ROWS_W  8    // roi height in rows

// ==============================
// pixel and row timing
// ==============================
// samples at or above this are white
`define BW_LEVEL  12'd2048

// invalid cycles in a row that close a line
`define EOL_GAP   6

`endif

// ==== hw/roi_pkg.sv ====
/* ROI detector shared types
   vector widths and the ROI state machine encoding */

`default_nettype none

`include "roi_defs.svh"

package roi_pkg;

  typedef logic [`PIX_W-1:0]  pixel_t;      // raw ccd sample
  typedef logic [`RUN_W-1:0]  run_len_t;    // white run length
  typedef logic [`THR_W-1:0]  threshold_t;  // row threshold
  typedef logic [`ROWS_W-1:0] roi_rows_t;   // roi height
  typedef logic [6:0]         seg7_t;       // segments g..a, active low

  // roi search progress within a frame
  typedef enum logic [1:0] {
    ROI_SEEK   = 2'd0,
    ROI_INSIDE = 2'd1,
    ROI_AFTER  = 2'd2
  } roi_state_e;

endpackage

`default_nettype wire

// ==== hw/ccd_pixel_front.sv ====
/* CCD pixel front end
   registers the camera bus and marks each valid pixel black or white */

`timescale 1ns/1ns
`default_nettype none

`include "roi_defs.svh"

module ccd_pixel_front
  import roi_pkg::*;
(
  input  wire logic   CCD_PIXCLK,
  input  wire logic   KEY,
  input  wire pixel_t ccd_data,
  input  wire logic   ccd_fval,
  input  wire logic   ccd_lval,
  output logic        pix_valid,
  output logic        pix_white,
  output logic        frame_valid
);

  pixel_t ccd_data_r;  // sampled pixel
  logic   lval_r;

  // ==============================
  // input registers
  // ==============================
  always_ff @(posedge CCD_PIXCLK)
  begin
    ccd_data_r <= ccd_data;
  end

  always_ff @(posedge CCD_PIXCLK or negedge KEY)
  begin
    if (!KEY)
    begin
      frame_valid <= 1'b0;
      lval_r      <= 1'b0;
    end
    else
    begin
      frame_valid <= ccd_fval;  // one cycle behind the pins
      lval_r      <= ccd_lval;
    end
  end

  // ==============================
  // classify stage
  // ==============================
  always_ff @(posedge CCD_PIXCLK or negedge KEY)
  begin
    if (!KEY)
      pix_valid <= 1'b0;
    else
      pix_valid <= frame_valid & lval_r;  // pixel inside both frame and line
  end

  // threshold against fixed level
  always_ff @(posedge CCD_PIXCLK)
  begin
    pix_white <= (ccd_data_r >= `BW_LEVEL);
  end

endmodule

`default_nettype wire

// ==== hw/row_white_run.sv ====
/* Row white-run measurement
   longest white run per row, one black pixel tolerated, end of row
   found from a gap of invalid cycles */

`timescale 1ns/1ns
`default_nettype none

`include "roi_defs.svh"

module row_white_run
  import roi_pkg::*;
(
  input  wire logic CCD_PIXCLK,
  input  wire logic KEY,
  input  wire logic pix_valid,
  input  wire logic pix_white,
  input  wire logic frame_valid,
  output logic      row_done,
  output run_len_t  row_max
);

  localparam int GAP_W = $clog2(`EOL_GAP + 1);

  run_len_t   run_cnt;     // current white run
  run_len_t   run_next;
  logic       noise_flag;  // one black pixel already absorbed
  logic       seen_pix;    // valid pixel since last row_done
  logic [GAP_W-1:0] gap_cnt;
  logic       gap_end;

  assign run_next = run_cnt + run_len_t'(1);

  // last invalid cycle before the gap reaches its length
  assign gap_end = !pix_valid && (gap_cnt == GAP_W'(`EOL_GAP - 1));

  // ==============================
  // gap counter and row strobe
  // ==============================
  always_ff @(posedge CCD_PIXCLK or negedge KEY)
  begin
    if (!KEY)
    begin
      gap_cnt  <= '0;
      row_done <= 1'b0;
    end
    else
    begin
      if (pix_valid)
        gap_cnt <= '0;
      else if (gap_cnt != GAP_W'(`EOL_GAP))
        gap_cnt <= gap_cnt + GAP_W'(1);  // saturates, one strobe per gap

      row_done <= gap_end && frame_valid && seen_pix;
    end
  end

  // ==============================
  // run tracking
  // ==============================
  always_ff @(posedge CCD_PIXCLK or negedge KEY)
  begin
    if (!KEY)
    begin
      run_cnt    <= '0;
      noise_flag <= 1'b0;
      seen_pix   <= 1'b0;
      row_max    <= '0;
    end
    else if (!frame_valid || row_done)
    begin
      // new row, row_max was sampled during the strobe
      run_cnt    <= '0;
      noise_flag <= 1'b0;
      seen_pix   <= 1'b0;
      row_max    <= '0;
    end
    else if (pix_valid)
    begin
      seen_pix <= 1'b1;
      if (pix_white)
      begin
        noise_flag <= 1'b0;
        run_cnt    <= run_next;
        if (run_next > row_max)
          row_max <= run_next;
      end
      else if (noise_flag)
        run_cnt <= '0;          // second black in a row breaks the run
      else
        noise_flag <= 1'b1;     // single black, run held
    end
  end

endmodule

`default_nettype wire

// ==== hw/roi_tracker.sv ====
/* ROI tracker
   finds the rows between two wide white rows with an adaptive
   threshold, handles the request button and frame-end rearming */

`timescale 1ns/1ns
`default_nettype none

module roi_tracker
  import roi_pkg::*;
(
  input  wire logic     CCD_PIXCLK,
  input  wire logic     KEY,
  input  wire logic     roi_start_n,
  input  wire logic     frame_valid,
  input  wire logic     row_done,
  input  wire run_len_t row_max,
  output roi_state_e    roi_state,
  output logic          record,
  output logic          done,
  output logic          error,
  output run_len_t      prev_run,
  output roi_rows_t     roi_rows
);

  logic       start_meta;
  logic       start_sync;   // button after two flops, still active low
  logic       start_req;
  logic       fv_d;
  logic       frame_end;
  logic       armed;
  logic       started;      // request already served this press
  threshold_t threshold;
  threshold_t wide_thr;     // prev_run * 1.5
  threshold_t narrow_thr;   // prev_run * 0.75
  threshold_t row_max_ext;

  assign start_req   = !start_sync;
  assign frame_end   = fv_d && !frame_valid;
  assign row_max_ext = threshold_t'(row_max);
  assign wide_thr    = threshold_t'(prev_run) + threshold_t'(prev_run >> 1);
  assign narrow_thr  = threshold_t'(prev_run >> 1) + threshold_t'(prev_run >> 2);

  // ==============================
  // button sync, frame edge
  // ==============================
  always_ff @(posedge CCD_PIXCLK or negedge KEY)
  begin
    if (!KEY)
    begin
      start_meta <= 1'b1;  // released
      start_sync <= 1'b1;
      fv_d       <= 1'b0;
    end
    else
    begin
      start_meta <= roi_start_n;
      start_sync <= start_meta;
      fv_d       <= frame_valid;
    end
  end

  // ==============================
  // roi state machine
  // ==============================
  always_ff @(posedge CCD_PIXCLK or negedge KEY)
  begin
    if (!KEY)
    begin
      roi_state <= ROI_SEEK;
      record    <= 1'b0;
      done      <= 1'b0;
      error     <= 1'b0;
      armed     <= 1'b0;
      started   <= 1'b0;
      threshold <= '0;
      prev_run  <= '0;
      roi_rows  <= '0;
    end
    else if (frame_end)
    begin
      threshold <= '0;
      prev_run  <= '0;
      if (roi_state == ROI_INSIDE)
        error <= 1'b1;  // frame ended mid roi, sticky
      if (start_req && !started)
      begin
        armed     <= 1'b1;
        started   <= 1'b1;
        done      <= 1'b0;
        record    <= 1'b0;
        roi_rows  <= '0;
        roi_state <= ROI_SEEK;
      end
      if (started && done && !start_req)
        started <= 1'b0;  // ready for the next press
    end
    else if (row_done)
    begin
      case (roi_state)
        ROI_SEEK:
        begin
          if ((row_max_ext < threshold) && armed)
          begin
            roi_state <= ROI_INSIDE;  // narrow row after wide ones
            record    <= 1'b1;
            threshold <= wide_thr;
          end
          else if (row_max_ext >= threshold)
            threshold <= narrow_thr;
        end
        ROI_INSIDE:
        begin
          if (row_max_ext > threshold)
          begin
            roi_state <= ROI_AFTER;   // closing wide row
            record    <= 1'b0;
            armed     <= 1'b0;
            done      <= 1'b1;
            threshold <= '0;
          end
          else
          begin
            threshold <= wide_thr;
            roi_rows  <= roi_rows + roi_rows_t'(1);
          end
        end
        default: ;  // ROI_AFTER holds until rearmed
      endcase
      prev_run <= row_max;
    end
  end

endmodule

`default_nettype wire

// ==== hw/seg7_display.sv ====
/* Seven-segment status display
   roi height on hex1..hex0, last row run on hex5..hex3 */

`timescale 1ns/1ns
`default_nettype none

module seg7_display
  import roi_pkg::*;
(
  input  wire run_len_t  prev_run,
  input  wire roi_rows_t roi_rows,
  output seg7_t          hex0,
  output seg7_t          hex1,
  output seg7_t          hex2,
  output seg7_t          hex3,
  output seg7_t          hex4,
  output seg7_t          hex5
);

  logic [11:0] run_ext;  // three digits of run length

  // active low, bit 6 is segment g
  function automatic seg7_t hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_to_seg = 7'b1000000;
      4'h1: hex_to_seg = 7'b1111001;
      4'h2: hex_to_seg = 7'b0100100;
      4'h3: hex_to_seg = 7'b0110000;
      4'h4: hex_to_seg = 7'b0011001;
      4'h5: hex_to_seg = 7'b0010010;
      4'h6: hex_to_seg = 7'b0000010;
      4'h7: hex_to_seg = 7'b1111000;
      4'h8: hex_to_seg = 7'b0000000;
      4'h9: hex_to_seg = 7'b0010000;
      4'ha: hex_to_seg = 7'b0001000;
      4'hb: hex_to_seg = 7'b0000011;
      4'hc: hex_to_seg = 7'b1000110;
      4'hd: hex_to_seg = 7'b0100001;
      4'he: hex_to_seg = 7'b0000110;
      default: hex_to_seg = 7'b0001110;  // F
    endcase
  endfunction

  assign run_ext = 12'(prev_run);

  assign hex0 = hex_to_seg(roi_rows[3:0]);
  assign hex1 = hex_to_seg(roi_rows[7:4]);
  assign hex2 = 7'b1111111;                 // spacer, all off
  assign hex3 = hex_to_seg(run_ext[3:0]);
  assign hex4 = hex_to_seg(run_ext[7:4]);
  assign hex5 = hex_to_seg(run_ext[11:8]);

endmodule

`default_nettype wire

// ==== hw/roi_detect_top.sv ====
/* ROI detector top level
   ccd front end, row run measurement, roi tracker and display */

`timescale 1ns/1ns
`default_nettype none

module roi_detect_top
  import roi_pkg::*;
(
  input  wire logic   CCD_PIXCLK,
  input  wire logic   KEY,
  input  wire pixel_t ccd_data,
  input  wire logic   ccd_fval,
  input  wire logic   ccd_lval,
  input  wire logic   roi_start_n,
  output seg7_t       hex0,
  output seg7_t       hex1,
  output seg7_t       hex2,
  output seg7_t       hex3,
  output seg7_t       hex4,
  output seg7_t       hex5,
  output logic [5:0]  led
);

  logic       pix_valid;
  logic       pix_white;
  logic       frame_valid;
  logic       row_done;
  run_len_t   row_max;
  roi_state_e roi_state;
  logic       record;
  logic       done;
  logic       error;
  run_len_t   prev_run;
  roi_rows_t  roi_rows;

  // status leds, state on the low two
  assign led = {row_done, record, done, error, roi_state};

  ccd_pixel_front ccd_pixel_front_i (
    .CCD_PIXCLK  (CCD_PIXCLK),
    .KEY         (KEY),
    .ccd_data    (ccd_data),
    .ccd_fval    (ccd_fval),
    .ccd_lval    (ccd_lval),
    .pix_valid   (pix_valid),
    .pix_white   (pix_white),
    .frame_valid (frame_valid)
  );

  row_white_run row_white_run_i (
    .CCD_PIXCLK  (CCD_PIXCLK),
    .KEY         (KEY),
    .pix_valid   (pix_valid),
    .pix_white   (pix_white),
    .frame_valid (frame_valid),
    .row_done    (row_done),
    .row_max     (row_max)
  );

  roi_tracker roi_tracker_i (
    .CCD_PIXCLK  (CCD_PIXCLK),
    .KEY         (KEY),
    .roi_start_n (roi_start_n),
    .frame_valid (frame_valid),
    .row_done    (row_done),
    .row_max     (row_max),
    .roi_state   (roi_state),
    .record      (record),
    .done        (done),
    .error       (error),
    .prev_run    (prev_run),
    .roi_rows    (roi_rows)
  );

  seg7_display seg7_display_i (
    .prev_run (prev_run),
    .roi_rows (roi_rows),
    .hex0     (hex0),
    .hex1     (hex1),
    .hex2     (hex2),
    .hex3     (hex3),
    .hex4     (hex4),
    .hex5     (hex5)
  );

endmodule

`default_nettype wire

// ==== test/roi_detect_assert.sv ====
/* ROI tracker assertions
   bound into the tracker, checks record, done and the row strobe */

`timescale 1ns/1ns
`default_nettype none

module roi_detect_assert
  import roi_pkg::*;
(
  input wire logic       CCD_PIXCLK,
  input wire logic       KEY,
  input wire roi_state_e roi_state,
  input wire logic       record,
  input wire logic       done,
  input wire logic       row_done
);

  // record only while inside the roi
  record_inside_roi: assert property (
    @(posedge CCD_PIXCLK) disable iff (!KEY)
      record |-> (roi_state == ROI_INSIDE)
  ) else $error("record high outside ROI_INSIDE");

  // one strobe per row
  row_done_single: assert property (
    @(posedge CCD_PIXCLK) disable iff (!KEY)
      row_done |=> !row_done
  ) else $error("row_done high on two consecutive cycles");

  done_record_apart: assert property (
    @(posedge CCD_PIXCLK) disable iff (!KEY)
      !(done && record)
  ) else $error("done and record high together");

endmodule

`default_nettype wire

// ==== test/roi_detect_tb.sv ====
/* ROI detector testbench
   plays table rows of white and black runs on the CCD bus and checks
   the hex digits and status leds after every row */

`timescale 1ns/1ns
`default_nettype none

`include "roi_defs.svh"

module roi_detect_tb
  import roi_pkg::*;
();

  localparam int N_ROWS  = 36;
  localparam int N_SEG   = 6;    // w, b, w, b, w, b
  localparam int GAP_CYC = 10;   // invalid cycles after each row
  localparam int FE_CYC  = 4;    // fval low at a frame end
  localparam int CLK_NS  = 100;
  localparam int unsigned SEED = 32'hbd44_8df6;

  // standard active-low hex digits with segment g as bit 6
  localparam seg7_t SEG_HEX [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                                     7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

  logic       CCD_PIXCLK;
  logic       KEY;
  pixel_t     ccd_data;
  logic       ccd_fval;
  logic       ccd_lval;
  logic       roi_start_n;
  seg7_t      hex0;
  seg7_t      hex1;
  seg7_t      hex2;
  seg7_t      hex3;
  seg7_t      hex4;
  seg7_t      hex5;
  logic [5:0] led;

  // stimulus and expected values per row
  int   run_tab   [N_ROWS][N_SEG];
  int   btn_tab   [N_ROWS];
  int   fe_tab    [N_ROWS];
  int   prev_tab  [N_ROWS];
  int   rows_tab  [N_ROWS];
  int   state_tab [N_ROWS];
  int   flag_tab  [N_ROWS];  // {record, done, error}
  logic table_ready;
  int   n_errors;
  int   n_checks;

  roi_detect_top roi_detect_top_i (
    .CCD_PIXCLK  (CCD_PIXCLK),
    .KEY         (KEY),
    .ccd_data    (ccd_data),
    .ccd_fval    (ccd_fval),
    .ccd_lval    (ccd_lval),
    .roi_start_n (roi_start_n),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3),
    .hex4        (hex4),
    .hex5        (hex5),
    .led         (led)
  );

  bind roi_tracker roi_detect_assert roi_detect_assert_i (
    .CCD_PIXCLK (CCD_PIXCLK),
    .KEY        (KEY),
    .roi_state  (roi_state),
    .record     (record),
    .done       (done),
    .row_done   (row_done)
  );

  always #(CLK_NS / 2) CCD_PIXCLK = ~CCD_PIXCLK;

  // ==============================
  // helpers
  // ==============================
  task automatic set_row(input int idx, input int w0, b0, w1, b1, w2, b2,
                         input int btn, fe, prev, rows, state, flags);
    run_tab[idx]   = '{w0, b0, w1, b1, w2, b2};
    btn_tab[idx]   = btn;
    fe_tab[idx]    = fe;
    prev_tab[idx]  = prev;
    rows_tab[idx]  = rows;
    state_tab[idx] = state;
    flag_tab[idx]  = flags;
  endtask

  task automatic load_table;
    //      row  w   b   w   b   w   b  btn fe prev rows state       rec/done/err
    set_row( 0,  5,  2, 12,  0,  0,  0, 1, 0, 12, 0, ROI_SEEK,   3'b000);
    set_row( 1,  3,  1,  4,  1,  3,  0, 1, 0, 10, 0, ROI_SEEK,   3'b000); // noise held
    set_row( 2,  6,  2,  5,  0,  0,  0, 1, 0,  6, 0, ROI_SEEK,   3'b000); // not armed
    set_row( 3, 300, 0,  0,  0,  0,  0, 1, 0, 300, 0, ROI_SEEK,  3'b000); // three digit run
    set_row( 4,  2,  3,  0,  0,  0,  0, 0, 1,  2, 0, ROI_SEEK,   3'b000); // press and arm
    set_row( 5,  0,  8,  0,  0,  0,  0, 0, 0,  0, 0, ROI_SEEK,   3'b000); // all black
    set_row( 6, 20,  0,  0,  0,  0,  0, 0, 0, 20, 0, ROI_SEEK,   3'b000);
    set_row( 7, 20,  0,  0,  0,  0,  0, 0, 0, 20, 0, ROI_SEEK,   3'b000);
    set_row( 8,  4,  0,  0,  0,  0,  0, 0, 0,  4, 0, ROI_INSIDE, 3'b100);
    set_row( 9,  5,  0,  0,  0,  0,  0, 0, 0,  5, 1, ROI_INSIDE, 3'b100);
    set_row(10,  6,  0,  0,  0,  0,  0, 0, 0,  6, 2, ROI_INSIDE, 3'b100);
    set_row(11, 30,  0,  0,  0,  0,  0, 0, 0, 30, 2, ROI_AFTER,  3'b010); // closing row
    set_row(12,  3,  0,  0,  0,  0,  0, 1, 1,  3, 2, ROI_AFTER,  3'b010); // release
    set_row(13,  3,  0,  0,  0,  0,  0, 0, 1,  3, 2, ROI_AFTER,  3'b010); // press again
    set_row(14,  3,  0,  0,  0,  0,  0, 1, 0,  3, 0, ROI_SEEK,   3'b000); // rearmed
    set_row(15, 20,  0,  0,  0,  0,  0, 1, 0, 20, 0, ROI_SEEK,   3'b000);
    set_row(16, 20,  0,  0,  0,  0,  0, 1, 0, 20, 0, ROI_SEEK,   3'b000);
    set_row(17,  4,  0,  0,  0,  0,  0, 1, 0,  4, 0, ROI_INSIDE, 3'b100);
    // sixteen rows inside carry roi_rows into hex1, the last one is cut by a frame end
    for (int k = 1; k <= 16; k++)
      set_row(17 + k, 4, 0, 0, 0, 0, 0, 1, int'(k == 16), 4, k, ROI_INSIDE, 3'b100);
    set_row(34,  4,  0,  0,  0,  0,  0, 1, 0,  4, 16, ROI_AFTER, 3'b011);
    set_row(35,  2,  0,  0,  0,  0,  0, 1, 0,  2, 16, ROI_AFTER, 3'b011); // error sticky
  endtask

  function automatic seg7_t seg_of(input logic [3:0] nib);
    return SEG_HEX[nib];
  endfunction

  // white pixels drawn above the level and black ones below it
  function automatic pixel_t rand_pixel(input logic white);
    if (white)
      return pixel_t'(`BW_LEVEL + ($urandom % ((1 << `PIX_W) - `BW_LEVEL)));
    else
      return pixel_t'($urandom % `BW_LEVEL);
  endfunction

  task automatic next_cycle;
    @(posedge CCD_PIXCLK);
    #5;
  endtask

  task automatic check_val(input string where, input string name,
                           input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got != exp)
    begin
      n_errors++;
      $display("** Error %s: %s = %h, expected %h", where, name, got, exp);
    end
  endtask

  task automatic check_outputs(input string where, input int prev, input int rows,
                               input int state, input int flags);
    logic [5:0] exp_led;
    exp_led = {1'b0, 3'(flags), 2'(state)};  // row strobe low by now
    check_val(where, "led", 8'(led), 8'(exp_led));
    check_val(where, "hex0", 8'(hex0), 8'(seg_of(4'(rows))));
    check_val(where, "hex1", 8'(hex1), 8'(seg_of(4'(rows >> 4))));
    check_val(where, "hex2", 8'(hex2), 8'h7f);
    check_val(where, "hex3", 8'(hex3), 8'(seg_of(4'(prev))));
    check_val(where, "hex4", 8'(hex4), 8'(seg_of(4'(prev >> 4))));
    check_val(where, "hex5", 8'(hex5), 8'(seg_of(4'(prev >> 8))));
  endtask

  // ==============================
  // row and frame playback
  // ==============================
  task automatic play_row(input int r);
    int pulses;
    pulses = 0;
    for (int s = 0; s < N_SEG; s++)
    begin
      for (int p = 0; p < run_tab[r][s]; p++)
      begin
        next_cycle();
        ccd_fval    = 1'b1;
        ccd_lval    = 1'b1;
        roi_start_n = 1'(btn_tab[r]);
        // first pixel of a segment sits right at the level
        if (p == 0)
          ccd_data = ((s % 2) == 0) ? pixel_t'(`BW_LEVEL) : pixel_t'(`BW_LEVEL - 1);
        else
          ccd_data = rand_pixel((s % 2) == 0);  // even entries white
      end
    end
    for (int g = 0; g < GAP_CYC; g++)
    begin
      next_cycle();
      if (led[5])
        pulses++;
      ccd_lval = 1'b0;
      ccd_data = '0;
    end
    n_checks++;
    if (pulses != 1)
    begin
      n_errors++;
      $display("row %0d: expected one row_done pulse in the line gap, saw %0d", r, pulses);
    end
  endtask

  task automatic end_frame;
    for (int i = 0; i < FE_CYC; i++)
    begin
      next_cycle();
      ccd_fval = 1'b0;
    end
  endtask

  initial
  begin
    CCD_PIXCLK  = 1'b0;
    KEY         = 1'b0;
    ccd_data    = '0;
    ccd_fval    = 1'b0;
    ccd_lval    = 1'b0;
    roi_start_n = 1'b1;  // button released
    n_errors    = 0;
    n_checks    = 0;
    table_ready = 1'b0;
    void'($urandom(SEED));
    load_table();
    table_ready = 1'b1;

    repeat (2) @(posedge CCD_PIXCLK);
    #5;
    KEY = 1'b1;
    check_outputs("after reset", 0, 0, ROI_SEEK, 3'b000);

    for (int r = 0; r < N_ROWS; r++)
    begin
      play_row(r);
      check_outputs($sformatf("row %0d", r), prev_tab[r], rows_tab[r],
                    state_tab[r], flag_tab[r]);
      if (fe_tab[r] != 0)
        end_frame();
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // watchdog allows twice the time of all rows at the longest row length
  initial
  begin
    int longest;
    int len;
    int wd_ns;
    longest = 0;
    wait (table_ready);
    for (int r = 0; r < N_ROWS; r++)
    begin
      len = 0;
      for (int s = 0; s < N_SEG; s++)
        len += run_tab[r][s];
      if (len > longest)
        longest = len;
    end
    wd_ns = N_ROWS * (longest + GAP_CYC) * CLK_NS * 2;
    #(wd_ns);
    $display("watchdog: the run did not finish within %0d ns", wd_ns);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/roi_pkg.sv
hw/ccd_pixel_front.sv
hw/row_white_run.sv
hw/roi_tracker.sv
hw/seg7_display.sv
hw/roi_detect_top.sv
test/roi_detect_assert.sv
test/roi_detect_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# verilator build and run of the roi detector testbench

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
SIM_BIN=roi_detect_sim
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
  -f filelist.f --top-module roi_detect_tb \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1
